// ==== src/ks_config.svh ====
`ifndef KS_CONFIG_SVH
`define KS_CONFIG_SVH

// voice layout
`define KS_NUM_VOICES 4         // peer voice engines
`define KS_VOICE_IW   2         // voice index bits, top of ram address
`define KS_VOICE_AW   8         // 256 words per voice region

// datapath widths
`define KS_SAMPLE_W   24        // audio word
`define KS_NOISE_W    16        // lfsr word
`define KS_VEL_W      7         // midi style velocity
`define KS_DECAY_W    12        // gain, 4096 would be unity
`define KS_FILT_W     2         // filter depth select
`define KS_MIX_W      24        // mixer output

// misc
`define KS_DEBOUNCE   4         // stable cycles before edge accepted
`define KS_LFSR_SEED  16'hACE1  // nonzero start
`define KS_LFSR_TAPS  16'hB400  // maximal length galois taps

`endif

// ==== src/ks_pkg.sv ====
`default_nettype none
`include "ks_config.svh"

package ks_pkg;

	typedef logic signed [`KS_SAMPLE_W-1:0] sample_t;  // audio sample
	typedef logic signed [`KS_NOISE_W-1:0]  noise_t;   // white noise word
	typedef logic [`KS_VEL_W-1:0]           vel_t;     // unsigned velocity
	typedef logic [`KS_DECAY_W-1:0]         decay_t;   // feedback gain, q12

	typedef logic [`KS_VOICE_AW-1:0] voice_addr_t;  // offset inside one region
	// voice index in the top bits, offset below
	typedef logic [`KS_VOICE_IW+`KS_VOICE_AW-1:0] ram_addr_t;

	typedef logic [`KS_FILT_W-1:0] filt_sel_t;  // 0 bypass, 1 two tap, 2/3 four tap

	typedef enum logic [1:0]
	{
		VOICE_IDLE,  // silent, no memory traffic
		VOICE_LOAD,  // filling region with scaled noise
		VOICE_RING   // recirculating through filter and decay
	} voice_state_t;

endpackage

`default_nettype wire

// ==== src/trig_debounce.sv ====
`default_nettype none
`include "ks_config.svh"

module trig_debounce
(
	input  logic a_clk,
	input  logic reset_n,   // active high
	input  logic trig_raw,  // async key contact
	output logic press      // one cycle on accepted rising edge
);

	localparam int CNT_W = $clog2(`KS_DEBOUNCE + 1);

	logic             sync0;   // first sync stage
	logic             sync1;   // second sync stage, safe to use
	logic             stable;  // debounced level
	logic [CNT_W-1:0] cnt;     // cycles input has disagreed

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			sync0  <= 1'b0;
			sync1  <= 1'b0;
			stable <= 1'b0;
			cnt    <= '0;
			press  <= 1'b0;
		end
		else
		begin
			sync0 <= trig_raw;
			sync1 <= sync0;
			press <= 1'b0;
			if (sync1 == stable)
				cnt <= '0;  // agreement resets the run
			else if (cnt == CNT_W'(`KS_DEBOUNCE - 1))
			begin
				stable <= sync1;  // run long enough, take new level
				cnt    <= '0;
				press  <= sync1;  // pulse only on the rising side
			end
			else
				cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/noise_lfsr.sv ====
`default_nettype none
`include "ks_config.svh"

module noise_lfsr
	import ks_pkg::*;
(
	input  logic   a_clk,
	input  logic   reset_n,
	output noise_t noise    // new word every cycle
);

	logic [`KS_NOISE_W-1:0] lfsr;

	// galois form, shift right and fold taps in when lsb falls out
	always_ff @(posedge a_clk)
	begin
		if (reset_n)
			lfsr <= `KS_LFSR_SEED;
		else
		begin
			lfsr <= (lfsr >> 1) ^ ({`KS_NOISE_W{lfsr[0]}} & `KS_LFSR_TAPS);
		end
	end

	assign noise = noise_t'(lfsr);  // reinterpret as two's complement

endmodule

`default_nettype wire

// ==== src/loop_filter.sv ====
`default_nettype none
`include "ks_config.svh"

module loop_filter
	import ks_pkg::*;
(
	input  logic      a_clk,
	input  logic      reset_n,
	input  logic      load,      // new read word on d
	input  logic      clear,     // voice restart
	input  filt_sel_t filt_sel,
	input  sample_t   d,
	output sample_t   q          // registered average
);

	localparam int SUM_W = `KS_SAMPLE_W + 2;  // headroom for four taps

	sample_t                  hist [4];  // hist[0] newest
	logic signed [SUM_W-1:0]  sum2;
	logic signed [SUM_W-1:0]  sum4;
	sample_t                  avg;
	logic                     avg_en;    // history moved last cycle

	always_comb
	begin
		sum2 = hist[0] + hist[1];
		sum4 = sum2 + hist[2] + hist[3];
		case (filt_sel)
			2'd0:    avg = hist[0];                  // straight through
			2'd1:    avg = sample_t'(sum2 >>> 1);    // mild lowpass
			default: avg = sample_t'(sum4 >>> 2);    // darker tone
		endcase
	end

	always_ff @(posedge a_clk)
	begin
		if (reset_n || clear)
		begin
			for (int i = 0; i < 4; i++)
				hist[i] <= '0;
			avg_en <= 1'b0;
			q      <= '0;
		end
		else
		begin
			avg_en <= load;
			if (load)
			begin
				hist[0] <= d;
				for (int i = 1; i < 4; i++)
					hist[i] <= hist[i-1];
			end
			if (avg_en)
				q <= avg;  // second stage, two cycles after d
		end
	end

endmodule

`default_nettype wire

// ==== src/ks_voice.sv ====
`default_nettype none
`include "ks_config.svh"

module ks_voice
	import ks_pkg::*;
(
	input  logic        a_clk,
	input  logic        reset_n,
	input  logic        sample_tick,
	input  logic        trig_raw,
	input  noise_t      noise,         // shared lfsr word
	input  vel_t        velocity,
	input  decay_t      decay,
	input  voice_addr_t delay_length,
	input  filt_sel_t   filt_sel,
	input  logic        ram_grant,     // write happens in this cycle
	input  logic        rd_valid,      // old word on rd_data
	input  sample_t     rd_data,
	output logic        ram_req,
	output voice_addr_t ram_addr,
	output sample_t     ram_wdata,
	output sample_t     voice_out,
	output logic        active
);

	voice_state_t state;
	voice_addr_t  ptr;       // current slot in region
	voice_addr_t  len_q;     // last slot, latched at start
	vel_t         vel_q;
	decay_t       decay_q;
	filt_sel_t    sel_q;
	logic         press;     // debounced edge
	logic         pend;      // press waiting for a tick
	logic         start;     // restart this cycle
	logic         rd_live;   // outstanding read belongs to ring phase
	sample_t      filt_q;
	logic signed [`KS_NOISE_W+`KS_VEL_W:0]    start_prod;  // noise x velocity
	logic signed [`KS_SAMPLE_W+`KS_DECAY_W:0] decay_prod;  // filter x gain

	trig_debounce u_dbnc (.a_clk(a_clk), .reset_n(reset_n), .trig_raw(trig_raw), .press(press));

	loop_filter u_filt
	(
		.a_clk(a_clk), .reset_n(reset_n),
		.load(rd_valid && rd_live),  // load phase reads hold stale words
		.clear(start), .filt_sel(sel_q), .d(rd_data), .q(filt_q)
	);

	assign start      = sample_tick && pend;
	assign start_prod = noise * $signed({1'b0, vel_q});
	assign decay_prod = filt_q * $signed({1'b0, decay_q});
	assign ram_addr   = ptr;
	assign ram_wdata  = (state == VOICE_LOAD) ? sample_t'(start_prod)
		: decay_prod[`KS_DECAY_W +: `KS_SAMPLE_W];  // arithmetic >>> 12
	assign voice_out  = filt_q;
	assign active     = (state != VOICE_IDLE);

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			state   <= VOICE_IDLE;
			ptr     <= '0;
			len_q   <= '0;
			vel_q   <= '0;
			decay_q <= '0;
			sel_q   <= '0;
			pend    <= 1'b0;
			ram_req <= 1'b0;
			rd_live <= 1'b0;
		end
		else
		begin
			if (ram_grant)
				rd_live <= (state == VOICE_RING);  // tag the read issued now
			if (sample_tick)
			begin
				pend    <= press;  // a press on the tick itself waits one sample
				ram_req <= pend || (state != VOICE_IDLE);
				if (pend)
				begin
					state   <= VOICE_LOAD;  // also retrigger from ring
					ptr     <= '0;
					len_q   <= delay_length;
					vel_q   <= velocity;
					decay_q <= decay;
					sel_q   <= filt_sel;
				end
			end
			else
			begin
				if (press)
					pend <= 1'b1;
				if (ram_grant)
				begin
					ram_req <= 1'b0;  // served for this sample
					if (ptr == len_q)
					begin
						ptr <= '0;  // wrap region
						if (state == VOICE_LOAD)
							state <= VOICE_RING;  // region full of noise
					end
					else
						ptr <= ptr + 1'b1;
				end
			end
		end
	end

	// arbiter grants only a voice that is asking
	a_grant_needs_req: assert property (@(posedge a_clk) disable iff (reset_n)
		ram_grant |-> ram_req);

endmodule

`default_nettype wire

// ==== src/delay_ram_arbiter.sv ====
`default_nettype none
`include "ks_config.svh"

module delay_ram_arbiter
	import ks_pkg::*;
(
	input  logic                      a_clk,
	input  logic                      reset_n,
	input  logic                      sample_tick,
	input  logic [`KS_NUM_VOICES-1:0] req,        // level until granted
	input  voice_addr_t               addr0,
	input  voice_addr_t               addr1,
	input  voice_addr_t               addr2,
	input  voice_addr_t               addr3,
	input  sample_t                   wdata0,
	input  sample_t                   wdata1,
	input  sample_t                   wdata2,
	input  sample_t                   wdata3,
	output logic [`KS_NUM_VOICES-1:0] grant,      // one hot pulse
	output logic [`KS_NUM_VOICES-1:0] rd_valid,   // grant delayed one cycle
	output sample_t                   rd_data,
	output logic                      mem_en,
	output ram_addr_t                 mem_addr,
	output sample_t                   mem_wdata,
	input  sample_t                   mem_rdata
);

	logic [`KS_VOICE_IW-1:0] gnt_idx;   // winner, forms region select
	voice_addr_t             addr_sel;
	sample_t                 wdata_sel;

	// fixed priority, voice 0 first
	always_comb
	begin
		grant     = '0;
		gnt_idx   = '0;
		addr_sel  = addr0;
		wdata_sel = wdata0;
		if (req[0])
			grant[0] = 1'b1;
		else if (req[1])
		begin
			grant[1]  = 1'b1;
			gnt_idx   = 2'd1;
			addr_sel  = addr1;
			wdata_sel = wdata1;
		end
		else if (req[2])
		begin
			grant[2]  = 1'b1;
			gnt_idx   = 2'd2;
			addr_sel  = addr2;
			wdata_sel = wdata2;
		end
		else if (req[3])
		begin
			grant[3]  = 1'b1;
			gnt_idx   = 2'd3;
			addr_sel  = addr3;
			wdata_sel = wdata3;
		end
	end

	assign mem_en    = |grant;
	assign mem_addr  = {gnt_idx, addr_sel};
	assign mem_wdata = wdata_sel;
	assign rd_data   = mem_rdata;  // memory output is already registered

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
			rd_valid <= '0;
		else
			rd_valid <= grant;  // matches memory read latency
	end

	// every voice must be served before the next sample starts
	a_all_served: assert property (@(posedge a_clk) disable iff (reset_n)
		sample_tick |-> (req == '0));
	// a served voice drops its request right away
	a_req_drops: assert property (@(posedge a_clk) disable iff (reset_n)
		(|grant) |=> ((req & $past(grant)) == '0));

endmodule

`default_nettype wire

// ==== src/delay_line_ram.sv ====
`default_nettype none
`include "ks_config.svh"

module delay_line_ram
	import ks_pkg::*;
(
	input  logic      a_clk,
	input  logic      en,     // read and write together
	input  ram_addr_t addr,
	input  sample_t   wdata,
	output sample_t   rdata   // old word, next cycle
);

	localparam int DEPTH = 1 << (`KS_VOICE_IW + `KS_VOICE_AW);

	sample_t mem [DEPTH];  // all voice regions back to back

	// read-before-write, old content leaves as new word goes in
	always_ff @(posedge a_clk)
	begin
		if (en)
		begin
			rdata     <= mem[addr];
			mem[addr] <= wdata;
		end
	end

endmodule

`default_nettype wire

// ==== src/ks_synth_top.sv ====
`default_nettype none
`include "ks_config.svh"

module ks_synth_top
	import ks_pkg::*;
(
	input  logic                      a_clk,
	input  logic                      reset_n,       // active high
	input  logic                      sample_tick,   // audio rate strobe
	input  logic [`KS_NUM_VOICES-1:0] trig,          // one key per voice
	input  vel_t                      velocity,
	input  decay_t                    decay,
	input  voice_addr_t               delay_length,  // pitch
	input  filt_sel_t                 filt_sel,
	output sample_t                   mix_out,
	output logic [`KS_NUM_VOICES-1:0] voice_active
);

	localparam int SUM_W = `KS_SAMPLE_W + $clog2(`KS_NUM_VOICES);
	localparam logic signed [SUM_W-1:0] MIX_MAX = SUM_W'((1 << (`KS_MIX_W - 1)) - 1);
	localparam logic signed [SUM_W-1:0] MIX_MIN = -MIX_MAX - 1;

	noise_t                    noise;
	logic [`KS_NUM_VOICES-1:0] v_req;
	logic [`KS_NUM_VOICES-1:0] v_grant;
	logic [`KS_NUM_VOICES-1:0] v_rd_valid;
	voice_addr_t               v_addr [`KS_NUM_VOICES];
	sample_t                   v_wdata [`KS_NUM_VOICES];
	sample_t                   v_out [`KS_NUM_VOICES];
	sample_t                   rd_data;
	logic                      mem_en;
	ram_addr_t                 mem_addr;
	sample_t                   mem_wdata;
	sample_t                   mem_rdata;
	logic signed [SUM_W-1:0]   mix_sum;  // full precision sum
	sample_t                   mix_sat;

	noise_lfsr u_lfsr (.a_clk(a_clk), .reset_n(reset_n), .noise(noise));

	genvar gv;
	generate
		for (gv = 0; gv < `KS_NUM_VOICES; gv++)
		begin : g_voice
			ks_voice u_voice
			(
				.a_clk(a_clk), .reset_n(reset_n), .sample_tick(sample_tick),
				.trig_raw(trig[gv]), .noise(noise), .velocity(velocity), .decay(decay),
				.delay_length(delay_length), .filt_sel(filt_sel),
				.ram_grant(v_grant[gv]), .rd_valid(v_rd_valid[gv]), .rd_data(rd_data),
				.ram_req(v_req[gv]), .ram_addr(v_addr[gv]), .ram_wdata(v_wdata[gv]),
				.voice_out(v_out[gv]), .active(voice_active[gv])
			);
		end
	endgenerate

	delay_ram_arbiter u_arb
	(
		.a_clk(a_clk), .reset_n(reset_n), .sample_tick(sample_tick), .req(v_req),
		.addr0(v_addr[0]), .addr1(v_addr[1]), .addr2(v_addr[2]), .addr3(v_addr[3]),
		.wdata0(v_wdata[0]), .wdata1(v_wdata[1]), .wdata2(v_wdata[2]), .wdata3(v_wdata[3]),
		.grant(v_grant), .rd_valid(v_rd_valid), .rd_data(rd_data),
		.mem_en(mem_en), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
	);

	delay_line_ram u_ram
	(
		.a_clk(a_clk), .en(mem_en), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
	);

	// sum all voices then clamp to output range
	always_comb
	begin
		mix_sum = '0;
		for (int i = 0; i < `KS_NUM_VOICES; i++)
		begin
			mix_sum = mix_sum + SUM_W'(v_out[i]);  // sign extended
		end
		if (mix_sum > MIX_MAX)
			mix_sat = sample_t'(MIX_MAX);
		else if (mix_sum < MIX_MIN)
			mix_sat = sample_t'(MIX_MIN);
		else
			mix_sat = sample_t'(mix_sum);
	end

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
			mix_out <= '0;
		else if (sample_tick)
			mix_out <= mix_sat;  // one sample per tick
	end

endmodule

`default_nettype wire

// ==== sim/ks_synth_tb.sv ====
`default_nettype none
`include "ks_config.svh"

module ks_synth_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TICK_PERIOD = 12;         // cycles per audio sample
	localparam int N_GLITCH    = 24;         // each glitch fits in one tick
	localparam int N_SINGLE    = 120;
	localparam int N_RETRIG    = 80;
	localparam int N_CHORD     = 100;
	localparam int TOTAL_TICKS = 3 + N_GLITCH + 2 + 3 + N_SINGLE + 4 + N_RETRIG + 12 + N_CHORD;
	localparam int WATCHDOG_NS = TOTAL_TICKS * TICK_PERIOD * 8 * 2;
	localparam int S_IDLE      = 0;
	localparam int S_LOAD      = 1;
	localparam int S_RING      = 2;
	localparam int MIX_MAX     = (1 << 23) - 1;
	localparam int MIX_MIN     = -(1 << 23);

	logic                        a_clk;
	logic                        reset_n;
	logic                        sample_tick = 1'b0;
	logic [`KS_NUM_VOICES-1:0]   trig;
	logic [`KS_VEL_W-1:0]        velocity;
	logic [`KS_DECAY_W-1:0]      decay;
	logic [`KS_VOICE_AW-1:0]     delay_length;
	logic [`KS_FILT_W-1:0]       filt_sel;
	logic signed [23:0]          mix_out;
	logic [`KS_NUM_VOICES-1:0]   voice_active;

	int          tick_cnt = 0;
	int          errors = 0;
	logic        chk_en;   // model compare enabled after reset
	string       phase;
	logic [31:0] rng;

	// reference model state updated once per edge
	logic [15:0]        m_lfsr;
	logic               m_s0 [4];
	logic               m_s1 [4];
	logic               m_stab [4];
	logic               m_press [4];
	int                 m_cnt [4];
	int                 m_state [4];
	int                 m_ptr [4];
	int                 m_len [4];
	int                 m_vel [4];
	int                 m_dec [4];
	int                 m_sel [4];
	logic               m_pend [4];
	logic               m_req [4];
	logic               m_live [4];   // read in flight is a ring read
	logic               m_avg_en [4];
	int                 m_hist [4][4];
	int                 m_q [4];       // voice output
	logic [3:0]         m_rdv;
	logic signed [23:0] m_rdata;
	logic signed [23:0] m_mem [1024];
	logic signed [23:0] m_mix;

	ks_synth_top UUT
	(
		.a_clk(a_clk), .reset_n(reset_n), .sample_tick(sample_tick), .trig(trig),
		.velocity(velocity), .decay(decay), .delay_length(delay_length),
		.filt_sel(filt_sel), .mix_out(mix_out), .voice_active(voice_active)
	);

	initial
	begin
		a_clk = 1'b0;
		forever #4 a_clk = ~a_clk;  // 8 ns period
	end

	always @(posedge a_clk)
	begin
		if (reset_n)
		begin
			tick_cnt    <= 0;
			sample_tick <= 1'b0;
		end
		else
		begin
			tick_cnt    <= (tick_cnt == TICK_PERIOD - 1) ? 0 : tick_cnt + 1;
			sample_tick <= (tick_cnt == TICK_PERIOD - 1);
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the test sequence did not finish in time");
		$display("SOME TESTS FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int pick(input int n);
		rng = xorshift(rng);
		return int'(rng % n);  // 0 .. n-1
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic wait_ticks(input int n);
		repeat (n)
		begin
			@(posedge a_clk);
			while (!sample_tick)
				@(posedge a_clk);
		end
	endtask

	task automatic set_controls(input logic loud);
		velocity     <= loud ? 7'd127 : 7'(1 + pick(127));
		decay        <= loud ? 12'(4000 + pick(96)) : 12'(3500 + pick(596));
		delay_length <= 8'(4 + pick(32));
		filt_sel     <= loud ? 2'd0 : 2'(pick(4));  // raw output pushes the clamp
	endtask

	// key held well past the debounce so the voice runs from the next tick
	task automatic press_voice(input int v);
		wait_ticks(1);
		trig[v] <= 1'b1;
		repeat (`KS_DEBOUNCE + 4) @(posedge a_clk);
		trig[v] <= 1'b0;
		wait_ticks(1);
		@(posedge a_clk);
		check_value({phase, " start"}, 1, voice_active[v]);
	endtask

	always @(posedge a_clk)
	begin : model_step
		int                 g;
		int                 avg;
		int                 sum;
		logic signed [15:0] nz;
		logic [9:0]         addr;
		logic signed [23:0] wd;
		logic [3:0]         act;
		for (int v = 0; v < 4; v++)
			act[v] = (m_state[v] != S_IDLE);
		if (chk_en)
		begin
			check_value({phase, " mix_out"}, m_mix, mix_out);
			check_value({phase, " voice_active"}, act, voice_active);
		end
		if (reset_n)
		begin
			m_lfsr = 16'hACE1;
			m_mix  = '0;
			m_rdv  = '0;
			for (int v = 0; v < 4; v++)
			begin
				m_s0[v]     = 1'b0;
				m_s1[v]     = 1'b0;
				m_stab[v]   = 1'b0;
				m_press[v]  = 1'b0;
				m_cnt[v]    = 0;
				m_state[v]  = S_IDLE;
				m_ptr[v]    = 0;
				m_sel[v]    = 0;
				m_pend[v]   = 1'b0;
				m_req[v]    = 1'b0;
				m_live[v]   = 1'b0;
				m_avg_en[v] = 1'b0;
				m_q[v]      = 0;
				for (int i = 0; i < 4; i++)
					m_hist[v][i] = 0;
			end
		end
		else
		begin
			nz = m_lfsr;
			g  = -1;
			for (int v = 3; v >= 0; v--)
				if (m_req[v])
					g = v;  // lowest index wins
			if (g >= 0)
			begin
				addr = 10'(g * 256 + m_ptr[g]);
				if (m_state[g] == S_LOAD)
					wd = 24'(int'(nz) * m_vel[g]);
				else
					wd = 24'((longint'(m_q[g]) * m_dec[g]) >>> 12);
			end
			if (sample_tick)
			begin
				sum = m_q[0] + m_q[1] + m_q[2] + m_q[3];
				if (sum > MIX_MAX)
					sum = MIX_MAX;
				else if (sum < MIX_MIN)
					sum = MIX_MIN;
				m_mix = 24'(sum);
			end
			for (int v = 0; v < 4; v++)
			begin
				if (sample_tick && m_pend[v])
				begin
					for (int i = 0; i < 4; i++)
						m_hist[v][i] = 0;  // restart clears the filter
					m_avg_en[v] = 1'b0;
					m_q[v]      = 0;
				end
				else
				begin
					case (m_sel[v])
						0:       avg = m_hist[v][0];
						1:       avg = (m_hist[v][0] + m_hist[v][1]) >>> 1;
						default:
							avg = (m_hist[v][0] + m_hist[v][1]
								+ m_hist[v][2] + m_hist[v][3]) >>> 2;
					endcase
					if (m_avg_en[v])
						m_q[v] = avg;
					m_avg_en[v] = m_rdv[v] && m_live[v];
					if (m_avg_en[v])
					begin
						for (int i = 3; i > 0; i--)
							m_hist[v][i] = m_hist[v][i-1];
						m_hist[v][0] = m_rdata;
					end
				end
			end
			m_rdv = '0;
			if (g >= 0)
			begin
				m_rdv[g]    = 1'b1;
				m_rdata     = m_mem[addr];  // old word out as new word goes in
				m_mem[addr] = wd;
			end
			for (int v = 0; v < 4; v++)
			begin
				if (g == v)
					m_live[v] = (m_state[v] == S_RING);
				if (sample_tick)
				begin
					m_req[v] = m_pend[v] || (m_state[v] != S_IDLE);
					if (m_pend[v])
					begin
						m_state[v] = S_LOAD;
						m_ptr[v]   = 0;
						m_len[v]   = delay_length;
						m_vel[v]   = velocity;
						m_dec[v]   = decay;
						m_sel[v]   = filt_sel;
					end
					m_pend[v] = m_press[v];
				end
				else
				begin
					if (m_press[v])
						m_pend[v] = 1'b1;
					if (g == v)
					begin
						m_req[v] = 1'b0;
						if (m_ptr[v] == m_len[v])
						begin
							m_ptr[v] = 0;
							if (m_state[v] == S_LOAD)
								m_state[v] = S_RING;
						end
						else
							m_ptr[v]++;
					end
				end
			end
			for (int v = 0; v < 4; v++)
			begin
				m_press[v] = 1'b0;
				if (m_s1[v] == m_stab[v])
					m_cnt[v] = 0;
				else if (m_cnt[v] == `KS_DEBOUNCE - 1)
				begin
					m_stab[v]  = m_s1[v];
					m_cnt[v]   = 0;
					m_press[v] = m_s1[v];  // rising side only
				end
				else
					m_cnt[v]++;
				m_s1[v] = m_s0[v];
				m_s0[v] = trig[v];
			end
			m_lfsr = {1'b0, m_lfsr[15:1]} ^ (m_lfsr[0] ? 16'hB400 : 16'h0000);
		end
	end

	initial
	begin
		int v;
		reset_n      = 1'b1;
		trig         = '0;
		velocity     = '0;
		decay        = '0;
		delay_length = '0;
		filt_sel     = '0;
		chk_en       = 1'b0;
		phase        = "reset";
		rng          = 32'h4d32e0fa;
		repeat (3) @(posedge a_clk);
		reset_n <= 1'b0;
		chk_en  <= 1'b1;
		wait_ticks(3);
		check_value("reset mix_out", 0, mix_out);
		check_value("reset voice_active", 0, voice_active);

		phase <= "glitch";
		repeat (N_GLITCH)
		begin
			v = pick(4);
			trig[v] <= 1'b1;
			repeat (1 + pick(`KS_DEBOUNCE - 1)) @(posedge a_clk);  // too short to count
			trig[v] <= 1'b0;
			repeat (4 + pick(4)) @(posedge a_clk);
		end
		wait_ticks(2);
		check_value("glitch voice_active", 0, voice_active);

		phase <= "single";
		set_controls(1'b0);
		press_voice(0);
		wait_ticks(N_SINGLE);  // load then long decay

		phase <= "retrigger";
		set_controls(1'b0);
		press_voice(0);
		wait_ticks(1);
		@(posedge a_clk);
		// cleared filter stays silent while the region reloads
		check_value("retrigger restart mix_out", 0, mix_out);
		wait_ticks(N_RETRIG);

		phase <= "chord";
		for (int i = 0; i < 4; i++)
		begin
			set_controls(1'b1);
			press_voice(i);
		end
		wait_ticks(N_CHORD);

		$display("checks done, %0d errors", errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== ks_synth_top.f ====
+incdir+src
src/ks_pkg.sv
src/trig_debounce.sv
src/noise_lfsr.sv
src/loop_filter.sv
src/ks_voice.sv
src/delay_ram_arbiter.sv
src/delay_line_ram.sv
src/ks_synth_top.sv
sim/ks_synth_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the synth testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module ks_synth_tb -f ks_synth_top.f -o ks_synth_sim

# the simulator status is not used, the printed verdict decides
sim_out="$(./obj_dir/ks_synth_sim)" || true
echo "$sim_out"
echo "$sim_out" | grep -q "^ALL TESTS PASSED$"
